// File: rtl/id_config.svh
// RV32I widths and encodings; the immediate layouts in the decoder assume XLEN of 32
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define ALU_OP_W    5
`define ALU_SEL_W   3

// major opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

// funct3, shared by OP and OP-IMM
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // srl / sra, split by funct7
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101

`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

`define F3_JALR     3'b000

`endif

// File: rtl/id_pkg.sv
// enum widths come from id_config.svh and must cover every value listed here
`include "id_config.svh"

package id_pkg;

    // operation handed to execute
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_JAL, ALU_JALR,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW
    } alu_op_e;

    // result class, picks the execute result mux
    typedef enum logic [`ALU_SEL_W-1:0] {
        SEL_NONE,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_COMPARE,
        SEL_BRANCH,
        SEL_LOAD,
        SEL_STORE
    } alu_sel_e;

endpackage

// File: rtl/inst_decoder.sv
// RV32I base set only; M, CSR and FENCE are illegal, branch and JAL offsets are left to execute
`timescale 1ns/1ps
`include "id_config.svh"

module inst_decoder
    import id_pkg::*;
(
    input  logic [`XLEN-1:0]       inst_i,
    input  logic [`XLEN-1:0]       pc_i,
    output alu_op_e                aluop_o,
    output alu_sel_e               alusel_o,
    output logic                   wreg_o,
    output logic [`REG_ADDR_W-1:0] rd_o,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic                   rs1_read_o,
    output logic                   rs2_read_o,
    output logic [`XLEN-1:0]       imm1_o,
    output logic [`XLEN-1:0]       imm2_o,
    output logic                   illegal_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             f7_zero;
    logic             f7_alt;  // sub / sra
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_sh;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign f7_zero    = inst_i[31:25] == 7'b0000000;
    assign f7_alt     = inst_i[31:25] == 7'b0100000;
    assign rd_o       = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_u  = {inst_i[31:12], 12'b0};
    assign imm_i  = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst_i[24:20]};

    // result class follows from the operation
    function automatic alu_sel_e sel_of(alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB:                        sel_of = SEL_ARITH;
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI:      sel_of = SEL_SHIFT;
            ALU_SLT, ALU_SLTU:                       sel_of = SEL_COMPARE;
            ALU_XOR, ALU_OR, ALU_AND:                sel_of = SEL_LOGIC;
            ALU_JAL, ALU_JALR:                       sel_of = SEL_BRANCH;
            ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU: sel_of = SEL_LOAD;
            ALU_SB, ALU_SH, ALU_SW:                  sel_of = SEL_STORE;
            default:                                 sel_of = SEL_NONE;  // cond. branches too
        endcase
    endfunction

    always_comb begin
        aluop_o    = ALU_NONE;
        wreg_o     = 1'b0;
        rs1_read_o = 1'b0;
        rs2_read_o = 1'b0;
        imm1_o     = '0;
        imm2_o     = '0;
        illegal_o  = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                aluop_o = ALU_LUI;
                wreg_o  = 1'b1;
                imm2_o  = imm_u;
            end
            `OPC_AUIPC: begin
                aluop_o = ALU_ADD;
                wreg_o  = 1'b1;
                imm1_o  = pc_i;
                imm2_o  = imm_u;
            end
            `OPC_JAL: begin
                aluop_o = ALU_JAL;
                wreg_o  = 1'b1;
            end
            `OPC_JALR: begin
                aluop_o    = ALU_JALR;
                wreg_o     = 1'b1;
                rs1_read_o = 1'b1;
                imm2_o     = imm_i;
                illegal_o  = funct3 != `F3_JALR;
            end
            `OPC_BRANCH: begin
                rs1_read_o = 1'b1;
                rs2_read_o = 1'b1;
                case (funct3)
                    `F3_BEQ:  aluop_o = ALU_BEQ;
                    `F3_BNE:  aluop_o = ALU_BNE;
                    `F3_BLT:  aluop_o = ALU_BLT;
                    `F3_BGE:  aluop_o = ALU_BGE;
                    `F3_BLTU: aluop_o = ALU_BLTU;
                    `F3_BGEU: aluop_o = ALU_BGEU;
                    default:  illegal_o = 1'b1;
                endcase
            end
            `OPC_LOAD: begin
                wreg_o     = 1'b1;
                rs1_read_o = 1'b1;
                imm2_o     = imm_i;  // address offset
                case (funct3)
                    `F3_LB:  aluop_o = ALU_LB;
                    `F3_LH:  aluop_o = ALU_LH;
                    `F3_LW:  aluop_o = ALU_LW;
                    `F3_LBU: aluop_o = ALU_LBU;
                    `F3_LHU: aluop_o = ALU_LHU;
                    default: illegal_o = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                rs1_read_o = 1'b1;
                rs2_read_o = 1'b1;  // store data
                case (funct3)
                    `F3_SB:  aluop_o = ALU_SB;
                    `F3_SH:  aluop_o = ALU_SH;
                    `F3_SW:  aluop_o = ALU_SW;
                    default: illegal_o = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                wreg_o     = 1'b1;
                rs1_read_o = 1'b1;
                imm2_o     = imm_i;
                case (funct3)
                    `F3_ADD:  aluop_o = ALU_ADD;
                    `F3_SLT:  aluop_o = ALU_SLT;
                    `F3_SLTU: aluop_o = ALU_SLTU;
                    `F3_XOR:  aluop_o = ALU_XOR;
                    `F3_OR:   aluop_o = ALU_OR;
                    `F3_AND:  aluop_o = ALU_AND;
                    `F3_SLL: begin
                        aluop_o   = ALU_SLL;
                        imm2_o    = imm_sh;
                        illegal_o = !f7_zero;
                    end
                    `F3_SR: begin
                        aluop_o   = f7_alt ? ALU_SRA : ALU_SRL;
                        imm2_o    = imm_sh;
                        illegal_o = !(f7_zero || f7_alt);
                    end
                endcase
            end
            `OPC_OP: begin
                wreg_o     = 1'b1;
                rs1_read_o = 1'b1;
                rs2_read_o = 1'b1;
                case (funct3)
                    `F3_ADD:  aluop_o = f7_alt ? ALU_SUB : ALU_ADD;
                    `F3_SLL:  aluop_o = ALU_SLL;
                    `F3_SLT:  aluop_o = ALU_SLT;
                    `F3_SLTU: aluop_o = ALU_SLTU;
                    `F3_XOR:  aluop_o = ALU_XOR;
                    `F3_SR:   aluop_o = f7_alt ? ALU_SRA : ALU_SRL;
                    `F3_OR:   aluop_o = ALU_OR;
                    `F3_AND:  aluop_o = ALU_AND;
                endcase
                // M extension rows (funct7 0000001) land here as well
                illegal_o = !(f7_zero || (f7_alt && (funct3 == `F3_ADD || funct3 == `F3_SR)));
            end
            default: illegal_o = 1'b1;  // fence, csr, system, custom
        endcase

        if (illegal_o) begin
            aluop_o    = ALU_NONE;
            wreg_o     = 1'b0;
            rs1_read_o = 1'b0;
            rs2_read_o = 1'b0;
            imm1_o     = '0;
            imm2_o     = '0;
        end
        alusel_o = sel_of(aluop_o);

        assert (!(wreg_o && illegal_o))
            else $error("decoder: register write on illegal encoding");
    end

endmodule

// File: rtl/operand_fwd.sv
// one source operand; a load in execute stalls on an address match whether or not it writes
`timescale 1ns/1ps
`include "id_config.svh"

module operand_fwd
    import id_pkg::*;
(
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic                   read_i,
    input  logic [`XLEN-1:0]       rf_data_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  logic [`XLEN-1:0]       ex_wdata_i,
    input  alu_op_e                ex_aluop_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wd_i,
    input  logic [`XLEN-1:0]       mem_wdata_i,
    output logic [`XLEN-1:0]       operand_o,
    output logic                   load_use_o
);

    logic ex_is_load;  // data not ready until mem
    logic addr_zero;

    assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
    assign addr_zero  = rd_addr_i == '0;

    always_comb begin
        operand_o  = imm_i;
        load_use_o = 1'b0;
        if (read_i) begin
            if (ex_is_load && ex_wd_i == rd_addr_i && !addr_zero) begin
                load_use_o = 1'b1;
                operand_o  = '0;
            end else if (addr_zero) begin
                operand_o = '0;  // x0, even if a later stage claims to write it
            end else if (ex_wreg_i && ex_wd_i == rd_addr_i) begin
                operand_o = ex_wdata_i;
            end else if (mem_wreg_i && mem_wd_i == rd_addr_i) begin
                operand_o = mem_wdata_i;
            end else begin
                operand_o = rf_data_i;
            end
        end

        assert (!load_use_o || read_i)
            else $error("operand_fwd: load-use raised without a register read");
    end

endmodule

// File: rtl/id_ex_reg.sv
// single entry; a flush only drops the instruction when the register can take a new one
`timescale 1ns/1ps
`include "id_config.svh"

module id_ex_reg
    import id_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  alu_op_e                aluop_i,
    input  alu_sel_e               alusel_i,
    input  logic                   wreg_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic [`XLEN-1:0]       op1_i,
    input  logic [`XLEN-1:0]       op2_i,
    input  logic                   illegal_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`XLEN-1:0]       out_pc_o,
    output alu_op_e                out_aluop_o,
    output alu_sel_e               out_alusel_o,
    output logic                   out_wreg_o,
    output logic [`REG_ADDR_W-1:0] out_rd_o,
    output logic [`XLEN-1:0]       out_op1_o,
    output logic [`XLEN-1:0]       out_op2_o,
    output logic                   out_illegal_o
);

    logic advance;  // entry empty or leaving this edge
    logic load;

    assign advance    = !out_valid_o || out_ready_i;
    assign in_ready_o = advance && !stall_i;
    assign load       = in_valid_i && in_ready_o && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o   <= 1'b0;
            out_wreg_o    <= 1'b0;
            out_illegal_o <= 1'b0;
        end else if (advance) begin
            out_valid_o   <= load;  // bubble on stall, flush or idle input
            out_wreg_o    <= load && wreg_i;
            out_illegal_o <= load && illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_pc_o     <= pc_i;
            out_aluop_o  <= aluop_i;
            out_alusel_o <= alusel_i;
            out_rd_o     <= rd_i;
            out_op1_o    <= op1_i;
            out_op2_o    <= op2_i;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_pc_o, out_aluop_o,
            out_alusel_o, out_wreg_o, out_rd_o, out_op1_o, out_op2_o, out_illegal_o}))
        else $error("id_ex_reg: output changed under back-pressure");

    a_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        !out_valid_o |-> !out_wreg_o)
        else $error("id_ex_reg: bubble carries a register write");

endmodule

// File: rtl/id_stage.sv
// stall and flush act on whatever is offered at in_valid_i; the register file must read combinationally
`timescale 1ns/1ps
`include "id_config.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  logic [`XLEN-1:0]       inst_i,
    input  logic [`XLEN-1:0]       pc_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic                   rs1_read_o,
    output logic                   rs2_read_o,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  logic [`XLEN-1:0]       ex_wdata_i,
    input  alu_op_e                ex_aluop_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wd_i,
    input  logic [`XLEN-1:0]       mem_wdata_i,
    input  logic                   ex_branch_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`XLEN-1:0]       out_pc_o,
    output alu_op_e                out_aluop_o,
    output alu_sel_e               out_alusel_o,
    output logic                   out_wreg_o,
    output logic [`REG_ADDR_W-1:0] out_rd_o,
    output logic [`XLEN-1:0]       out_op1_o,
    output logic [`XLEN-1:0]       out_op2_o,
    output logic                   out_illegal_o
);

    alu_op_e                dec_aluop;
    alu_sel_e               dec_alusel;
    logic                   dec_wreg;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic [`XLEN-1:0]       dec_imm1;
    logic [`XLEN-1:0]       dec_imm2;
    logic                   dec_illegal;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic                   rs1_load_use;
    logic                   rs2_load_use;

    inst_decoder u_decoder (
        .inst_i,
        .pc_i,
        .aluop_o    (dec_aluop),
        .alusel_o   (dec_alusel),
        .wreg_o     (dec_wreg),
        .rd_o       (dec_rd),
        .rs1_addr_o,
        .rs2_addr_o,
        .rs1_read_o,
        .rs2_read_o,
        .imm1_o     (dec_imm1),
        .imm2_o     (dec_imm2),
        .illegal_o  (dec_illegal)
    );

    operand_fwd u_fwd_rs1 (
        .rd_addr_i  (rs1_addr_o),
        .read_i     (rs1_read_o),
        .rf_data_i  (rs1_data_i),
        .imm_i      (dec_imm1),  // pc for auipc
        .ex_wreg_i,
        .ex_wd_i,
        .ex_wdata_i,
        .ex_aluop_i,
        .mem_wreg_i,
        .mem_wd_i,
        .mem_wdata_i,
        .operand_o  (op1),
        .load_use_o (rs1_load_use)
    );

    operand_fwd u_fwd_rs2 (
        .rd_addr_i  (rs2_addr_o),
        .read_i     (rs2_read_o),
        .rf_data_i  (rs2_data_i),
        .imm_i      (dec_imm2),
        .ex_wreg_i,
        .ex_wd_i,
        .ex_wdata_i,
        .ex_aluop_i,
        .mem_wreg_i,
        .mem_wd_i,
        .mem_wdata_i,
        .operand_o  (op2),
        .load_use_o (rs2_load_use)
    );

    id_ex_reg u_id_ex_reg (
        .clk,
        .rst_n_i,
        .in_valid_i,
        .in_ready_o,
        .stall_i    (rs1_load_use | rs2_load_use),
        .flush_i    (ex_branch_i),  // taken branch in execute
        .pc_i,
        .aluop_i    (dec_aluop),
        .alusel_i   (dec_alusel),
        .wreg_i     (dec_wreg),
        .rd_i       (dec_rd),
        .op1_i      (op1),
        .op2_i      (op2),
        .illegal_i  (dec_illegal),
        .out_valid_o,
        .out_ready_i,
        .out_pc_o,
        .out_aluop_o,
        .out_alusel_o,
        .out_wreg_o,
        .out_rd_o,
        .out_op1_o,
        .out_op2_o,
        .out_illegal_o
    );

endmodule

// File: testbench/tb_id_stage.sv
// reference model covers only the instruction forms sent here; register file model is combinational
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id_stage
    import id_pkg::*;
;

    localparam int REC_W       = 111;  // pc, op, sel, wreg, rd, op1, op2, illegal
    localparam int TEST_CYCLES = 48;   // reset plus all sequences below
    localparam int MARGIN      = 32;

    logic                   clk;
    logic                   rst_n_i;
    logic                   in_valid_i;
    logic                   in_ready_o;
    logic [`XLEN-1:0]       inst_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`REG_ADDR_W-1:0] rs1_addr_o;
    logic [`REG_ADDR_W-1:0] rs2_addr_o;
    logic                   rs1_read_o;
    logic                   rs2_read_o;
    logic [`XLEN-1:0]       rs1_data_i;
    logic [`XLEN-1:0]       rs2_data_i;
    logic                   ex_wreg_i;
    logic [`REG_ADDR_W-1:0] ex_wd_i;
    logic [`XLEN-1:0]       ex_wdata_i;
    alu_op_e                ex_aluop_i;
    logic                   mem_wreg_i;
    logic [`REG_ADDR_W-1:0] mem_wd_i;
    logic [`XLEN-1:0]       mem_wdata_i;
    logic                   ex_branch_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    logic [`XLEN-1:0]       out_pc_o;
    alu_op_e                out_aluop_o;
    alu_sel_e               out_alusel_o;
    logic                   out_wreg_o;
    logic [`REG_ADDR_W-1:0] out_rd_o;
    logic [`XLEN-1:0]       out_op1_o;
    logic [`XLEN-1:0]       out_op2_o;
    logic                   out_illegal_o;

    logic [`XLEN-1:0] rf [32];
    logic [REC_W-1:0] exp_q [$];
    logic [REC_W-1:0] exp_head;
    logic [REC_W-1:0] out_rec;
    logic             exp_avail;
    logic             ref_stall;
    logic [`XLEN-1:0] pc_next;
    integer           seed;
    int               errors;
    int               accepted;
    int               produced;

    // scratch for the stall model
    alu_op_e          s_op;
    logic             s_wreg;
    logic             s_r1;
    logic             s_r2;
    logic             s_bad;
    logic [`XLEN-1:0] s_imm1;
    logic [`XLEN-1:0] s_imm2;

    id_stage i_dut (.*);

    always #20 clk = ~clk;

    assign rs1_data_i = rf[rs1_addr_o];
    assign rs2_data_i = rf[rs2_addr_o];
    assign out_rec    = {out_pc_o, out_aluop_o, out_alusel_o, out_wreg_o, out_rd_o,
                         out_op1_o, out_op2_o, out_illegal_o};

    task automatic log_mismatch(input string what);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, what);
    endtask

    function automatic alu_op_e op_of_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:  return ALU_SLL;
            `F3_SLT:  return ALU_SLT;
            `F3_SLTU: return ALU_SLTU;
            `F3_XOR:  return ALU_XOR;
            `F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   return ALU_OR;
            default:  return ALU_AND;
        endcase
    endfunction

    function automatic alu_sel_e class_of(input alu_op_e op);
        if (op inside {ALU_ADD, ALU_SUB}) return SEL_ARITH;
        if (op inside {ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI}) return SEL_SHIFT;
        if (op inside {ALU_SLT, ALU_SLTU}) return SEL_COMPARE;
        if (op inside {ALU_XOR, ALU_OR, ALU_AND}) return SEL_LOGIC;
        if (op == ALU_JAL) return SEL_BRANCH;
        if (op == ALU_SW) return SEL_STORE;
        return SEL_NONE;
    endfunction

    function automatic void decode_ref(input logic [31:0] inst, input logic [31:0] pc,
                                       output alu_op_e op, output logic wreg,
                                       output logic r1, output logic r2,
                                       output logic [31:0] imm1, output logic [31:0] imm2,
                                       output logic bad);
        logic [2:0] f3;
        logic [6:0] f7;
        f3   = inst[14:12];
        f7   = inst[31:25];
        op   = ALU_NONE;
        wreg = 1'b1;
        r1   = 1'b0;
        r2   = 1'b0;
        imm1 = '0;
        imm2 = '0;
        bad  = 1'b0;
        case (inst[6:0])
            `OPC_LUI: begin
                op   = ALU_LUI;
                imm2 = {inst[31:12], 12'h000};
            end
            `OPC_AUIPC: begin
                op   = ALU_ADD;
                imm1 = pc;
                imm2 = {inst[31:12], 12'h000};
            end
            `OPC_JAL: op = ALU_JAL;
            `OPC_STORE: begin
                op   = ALU_SW;  // only sw is sent
                wreg = 1'b0;
                r1   = 1'b1;
                r2   = 1'b1;
                bad  = f3 != `F3_SW;
            end
            `OPC_OP_IMM: begin
                r1 = 1'b1;
                if (f3 == `F3_SLL || f3 == `F3_SR) begin
                    op   = op_of_f3(f3, inst[30]);
                    imm2 = {27'b0, inst[24:20]};
                    bad  = f7 != 7'h00 && !(f3 == `F3_SR && f7 == 7'h20);
                end else begin
                    op   = op_of_f3(f3, 1'b0);
                    imm2 = {{20{inst[31]}}, inst[31:20]};
                end
            end
            `OPC_OP: begin
                r1  = 1'b1;
                r2  = 1'b1;
                op  = op_of_f3(f3, inst[30]);
                bad = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == `F3_ADD || f3 == `F3_SR));
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            op   = ALU_NONE;
            wreg = 1'b0;
            r1   = 1'b0;
            r2   = 1'b0;
            imm1 = '0;
            imm2 = '0;
        end
    endfunction

    // execute over memory over register file, x0 always zero
    function automatic logic [31:0] operand_ref(input logic [4:0] addr, input logic rd,
                                                input logic [31:0] imm);
        if (!rd) return imm;
        if (addr == 5'd0) return '0;
        if (ex_wreg_i && ex_wd_i == addr) return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == addr) return mem_wdata_i;
        return rf[addr];
    endfunction

    function automatic logic [REC_W-1:0] build_record();
        alu_op_e     op;
        logic        wreg;
        logic        r1;
        logic        r2;
        logic        bad;
        logic [31:0] imm1;
        logic [31:0] imm2;
        decode_ref(inst_i, pc_i, op, wreg, r1, r2, imm1, imm2, bad);
        return {pc_i, op, class_of(op), wreg, inst_i[11:7],
                operand_ref(inst_i[19:15], r1, imm1), operand_ref(inst_i[24:20], r2, imm2), bad};
    endfunction

    always_comb begin
        decode_ref(inst_i, pc_i, s_op, s_wreg, s_r1, s_r2, s_imm1, s_imm2, s_bad);
        ref_stall = (ex_aluop_i inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU}) &&
            ((s_r1 && inst_i[19:15] != 5'd0 && inst_i[19:15] == ex_wd_i) ||
             (s_r2 && inst_i[24:20] != 5'd0 && inst_i[24:20] == ex_wd_i));
    end

    // expected records in acceptance order
    always @(posedge clk) begin
        if (!rst_n_i) begin
            exp_q.delete();
        end else begin
            if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                produced++;
            end
            if (in_valid_i && in_ready_o && !ex_branch_i) begin
                exp_q.push_back(build_record());
                accepted++;
            end
        end
        exp_avail <= exp_q.size() != 0;
        if (exp_q.size() != 0)
            exp_head <= exp_q[0];
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !out_valid_o && !out_wreg_o && in_ready_o)
        else log_mismatch("outputs after reset");

    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_ready_o == ((!out_valid_o || out_ready_i) && !ref_stall))
        else log_mismatch("in_ready_o against load-use and back-pressure");

    a_rf_reads: assert property (@(posedge clk) disable iff (!rst_n_i)
        rs1_read_o == s_r1 && rs2_read_o == s_r2 &&
        (!s_r1 || rs1_addr_o == inst_i[19:15]) && (!s_r2 || rs2_addr_o == inst_i[24:20]))
        else log_mismatch("register file read enables or addresses");

    a_record: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && out_ready_i |-> exp_avail && out_rec == exp_head)
        else log_mismatch($sformatf("record %h, expected %h", out_rec, exp_head));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_valid_i && in_ready_o && !ex_branch_i |=> out_valid_o)
        else log_mismatch("accepted instruction missing one cycle later");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rec))
        else log_mismatch("output changed under back-pressure");

    a_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_valid_i && in_ready_o && ex_branch_i |=> !out_valid_o)
        else log_mismatch("flushed instruction reached the output");

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OPC_STORE};
    endfunction

    task automatic present(input logic [31:0] inst);
        in_valid_i <= 1'b1;
        inst_i     <= inst;
        pc_i       <= pc_next;
        pc_next     = pc_next + 32'd4;
    endtask

    task automatic wait_accept();
        @(posedge clk);
        while (!in_ready_o)
            @(posedge clk);
    endtask

    task automatic issue(input logic [31:0] inst);
        present(inst);
        wait_accept();
        in_valid_i <= 1'b0;
    endtask

    task automatic set_fwd(input logic ex_w, input logic [4:0] ex_d, input alu_op_e ex_op,
                           input logic mem_w, input logic [4:0] mem_d);
        ex_wreg_i   <= ex_w;
        ex_wd_i     <= ex_d;
        ex_aluop_i  <= ex_op;
        ex_wdata_i  <= $random(seed);
        mem_wreg_i  <= mem_w;
        mem_wd_i    <= mem_d;
        mem_wdata_i <= $random(seed);
    endtask

    task automatic stall_then_release(input logic [31:0] inst, input logic [4:0] src);
        set_fwd(1'b1, src, ALU_LW, 1'b0, 5'd0);
        present(inst);
        repeat (3) @(posedge clk);
        set_fwd(1'b0, 5'd0, ALU_NONE, 1'b1, src);  // load moved on to memory
        wait_accept();
        in_valid_i <= 1'b0;
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * 40);
        $display("timeout: the test sequence did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        ex_aluop_i  = ALU_NONE;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        ex_branch_i = 1'b0;
        out_ready_i = 1'b1;
        pc_next     = 32'h0000_1000;
        seed        = 42;
        errors      = 0;
        accepted    = 0;
        produced    = 0;
        for (int i = 0; i < 32; i++)
            rf[i] = $random(seed);  // x0 too, must never show up

        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);

        issue(enc_i(12'hffd, 5'd2, `F3_ADD, 5'd1));             // addi
        issue(enc_i(12'h005, 5'd3, `F3_SLT, 5'd4));             // slti
        issue(enc_i(12'h007, 5'd5, `F3_SLL, 5'd6));             // slli
        issue(enc_i({7'h20, 5'd9}, 5'd7, `F3_SR, 5'd8));        // srai
        issue(enc_u(20'habcde, 5'd9, `OPC_LUI));
        issue(enc_u(20'h12345, 5'd10, `OPC_AUIPC));
        issue(enc_u(20'h00400, 5'd1, `OPC_JAL));
        issue(enc_sw(12'h010, 5'd11, 5'd12));
        issue(32'h0000_000f);                                   // fence
        issue(enc_r(7'h01, 5'd2, 5'd3, `F3_ADD, 5'd4));         // mul

        set_fwd(1'b0, 5'd0, ALU_NONE, 1'b0, 5'd0);
        issue(enc_r(7'h00, 5'd7, 5'd6, `F3_ADD, 5'd5));
        set_fwd(1'b0, 5'd0, ALU_NONE, 1'b1, 5'd6);
        issue(enc_r(7'h20, 5'd7, 5'd6, `F3_ADD, 5'd5));         // sub
        set_fwd(1'b1, 5'd6, ALU_ADD, 1'b1, 5'd6);
        issue(enc_r(7'h00, 5'd7, 5'd6, `F3_XOR, 5'd5));
        set_fwd(1'b1, 5'd7, ALU_ADD, 1'b1, 5'd6);
        issue(enc_r(7'h00, 5'd7, 5'd6, `F3_OR, 5'd5));
        set_fwd(1'b1, 5'd0, ALU_ADD, 1'b1, 5'd0);
        issue(enc_r(7'h00, 5'd0, 5'd0, `F3_AND, 5'd5));
        set_fwd(1'b0, 5'd6, ALU_SW, 1'b0, 5'd0);                // store in ex
        issue(enc_r(7'h00, 5'd7, 5'd6, `F3_ADD, 5'd5));

        stall_then_release(enc_r(7'h00, 5'd7, 5'd6, `F3_ADD, 5'd5), 5'd6);
        stall_then_release(enc_sw(12'h020, 5'd7, 5'd6), 5'd7);

        set_fwd(1'b0, 5'd0, ALU_NONE, 1'b0, 5'd0);
        ex_branch_i <= 1'b1;
        issue(enc_i(12'h001, 5'd2, `F3_ADD, 5'd3));
        ex_branch_i <= 1'b0;
        issue(enc_i(12'h002, 5'd2, `F3_ADD, 5'd3));

        // back-pressure with an empty register first
        @(posedge clk);
        out_ready_i <= 1'b0;
        issue(enc_i(12'h011, 5'd4, `F3_XOR, 5'd12));
        present(enc_i(12'h022, 5'd4, `F3_OR, 5'd13));
        repeat (4) @(posedge clk);
        out_ready_i <= 1'b1;
        wait_accept();
        in_valid_i <= 1'b0;

        repeat (3) @(posedge clk);
        assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("%0d accepted instructions never left the stage", exp_q.size());
            end
        $display("errors: %0d, accepted: %0d, produced: %0d", errors, accepted, produced);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_fwd.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
testbench/tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the id_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tb_id_stage \
    -o sim_tb_id_stage

sim_out=$(./obj_dir/sim_tb_id_stage)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi
